/* common/limn_pkg.sv */
`default_nettype none

package limn_pkg;

    ////////////////////////////////
    // Widths
    ////////////////////////////////
    typedef logic [31:0] word_t;    // Data word or byte address
    typedef logic [4:0]  reg_idx_t; // General register number
    typedef logic [5:0]  opcode_t;  // Low opcode field inst_lo

    ////////////////////////////////
    // Opcodes
    ////////////////////////////////
    localparam opcode_t op_tnop      = 6'b00_0000; // All-zero word does nothing
    localparam opcode_t op_addi      = 6'b11_1100;
    localparam opcode_t op_subi      = 6'b11_0100;
    localparam opcode_t op_andi      = 6'b01_1100;
    localparam opcode_t op_xori      = 6'b01_0100;
    localparam opcode_t op_ori       = 6'b00_1100;
    localparam opcode_t op_lui       = 6'b00_0100;
    localparam opcode_t op_beq       = 6'b11_1101;
    localparam opcode_t op_bne       = 6'b11_0101;
    localparam opcode_t op_j         = 6'b00_0110;
    localparam opcode_t op_jal       = 6'b00_0111;
    localparam opcode_t op_load_long = 6'b10_1011;
    localparam opcode_t op_store_reg = 6'b10_1010; // Data from opreg2
    localparam opcode_t op_store_imm = 6'b00_1010; // Data from imm5

    // Link register for JAL
    localparam reg_idx_t reg_lr = 5'd31;

    // Execute sequencer
    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_memory,
        st_halted
    } core_state_e;

endpackage

`default_nettype wire

/* execute/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire limn_pkg::reg_idx_t rs_idx,
    input  wire limn_pkg::reg_idx_t rt_idx,
    input  wire                     wr_en,
    input  wire limn_pkg::reg_idx_t wr_idx,
    input  wire limn_pkg::word_t    wr_data,
    output limn_pkg::word_t         rs_data,
    output limn_pkg::word_t         rt_data
);
    import limn_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != 5'd0)) begin // r0 stays zero
            regs[wr_idx] <= wr_data;
        end
    end

    // Two asynchronous read ports
    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];

endmodule

`default_nettype wire

/* execute/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit #(
    parameter limn_pkg::word_t reset_vector = 32'hFFFE_0000
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  inst_valid,
    input  wire limn_pkg::word_t inst,
    input  wire                  mem_done,
    input  wire limn_pkg::word_t load_data,
    input  wire limn_pkg::word_t rs_data,
    input  wire limn_pkg::word_t rt_data,
    output logic                 fetch_start,
    output limn_pkg::word_t      pc,
    output logic                 mem_start,
    output limn_pkg::word_t      mem_addr,
    output logic                 mem_we,
    output limn_pkg::word_t      mem_wdata,
    output limn_pkg::reg_idx_t   rs_idx,
    output limn_pkg::reg_idx_t   rt_idx,
    output logic                 wr_en,
    output limn_pkg::reg_idx_t   wr_idx,
    output limn_pkg::word_t      wr_data,
    output logic                 halted
);
    import limn_pkg::*;

    core_state_e state;
    logic        boot;         // Kicks the first fetch after reset
    opcode_t     opcode;
    reg_idx_t    opreg1;
    reg_idx_t    opreg2;
    word_t       imm16;
    logic [4:0]  imm5;
    word_t       br_offset;
    word_t       jump_target;
    word_t       pc_plus4;
    word_t       alu_result;
    word_t       next_pc;
    logic        is_alu;
    logic        is_mem;
    logic        is_load;
    logic        known;

    ////////////////////////////////
    // Field decode
    ////////////////////////////////
    assign opcode      = inst[5:0];
    assign opreg1      = inst[10:6];
    assign opreg2      = inst[15:11];
    assign imm16       = {16'h0000, inst[31:16]};  // Zero-extended
    assign imm5        = inst[31:27];
    assign br_offset   = {7'd0, inst[31:9], 2'b00};
    assign jump_target = {pc[31], inst[31:3], 2'b00}; // Top bit of pc survives
    assign pc_plus4    = pc + 32'd4;
    assign is_load     = opcode == op_load_long;

    assign rs_idx = opreg1;
    assign rt_idx = opreg2;

    always_comb begin
        alu_result = rt_data;
        next_pc    = pc_plus4;
        is_alu     = 1'b0;
        is_mem     = 1'b0;
        known      = 1'b1;
        case (opcode)
            op_tnop: begin
                next_pc = pc_plus4;
            end
            op_addi, op_subi, op_andi, op_xori, op_ori, op_lui: begin
                is_alu = 1'b1;
                case (opcode)
                    op_addi: alu_result = rt_data + imm16;
                    op_subi: alu_result = rt_data - imm16;
                    op_andi: alu_result = rt_data & imm16;
                    op_xori: alu_result = rt_data ^ imm16;
                    op_ori:  alu_result = rt_data | imm16;
                    default: alu_result = rt_data | (imm16 << 16); // LUI
                endcase
            end
            op_beq: begin
                if (rs_data == '0) begin
                    next_pc = pc + br_offset;
                end
            end
            op_bne: begin
                if (rs_data != '0) begin
                    next_pc = pc + br_offset;
                end
            end
            op_j, op_jal: begin
                next_pc = jump_target;
            end
            op_load_long, op_store_reg, op_store_imm: begin
                is_mem = 1'b1;
            end
            default: begin
                known = 1'b0;                  // Stops the core
            end
        endcase
    end

    // Memory request, taken by the load/store unit in the execute cycle
    assign mem_start = (state == st_execute) && is_mem;
    assign mem_we    = !is_load;
    assign mem_addr  = (is_load ? rt_data : rs_data) + imm16;
    assign mem_wdata = (opcode == op_store_reg) ? rt_data : {27'd0, imm5};

    // Register write port
    assign wr_en   = ((state == st_execute) && (is_alu || opcode == op_jal)) ||
                     ((state == st_memory) && mem_done && is_load);
    assign wr_idx  = (opcode == op_jal) ? reg_lr : opreg1;
    assign wr_data = (state == st_memory) ? load_data :
                     (opcode == op_jal) ? pc_plus4 : alu_result;

    assign halted = state == st_halted;

    ////////////////////////////////
    // Sequencer
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= st_fetch;
            pc          <= reset_vector;
            boot        <= 1'b1;
            fetch_start <= 1'b0;
        end else begin
            boot        <= 1'b0;
            fetch_start <= boot;
            case (state)
                st_fetch: begin
                    if (inst_valid) begin
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    if (is_mem) begin
                        state <= st_memory;
                        pc    <= pc_plus4;
                    end else if (known) begin
                        state       <= st_fetch;
                        pc          <= next_pc;
                        fetch_start <= 1'b1;
                    end else begin
                        state <= st_halted;   // Held until reset
                    end
                end
                st_memory: begin
                    if (mem_done) begin
                        state       <= st_fetch;
                        fetch_start <= 1'b1;
                    end
                end
                default: begin
                    state <= st_halted;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  fetch_start,
    input  wire limn_pkg::word_t pc,
    input  wire                  fetch_done,
    input  wire limn_pkg::word_t rd_data,
    output logic                 fetch_req,
    output limn_pkg::word_t      fetch_addr,
    output logic                 inst_valid,
    output limn_pkg::word_t      inst
);
    ////////////////////////////////
    // Request control
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_req  <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= fetch_done;       // One cycle after the bus answers
            if (fetch_start) begin
                fetch_req <= 1'b1;
            end else if (fetch_done) begin
                fetch_req <= 1'b0;
            end
        end
    end

    // Address and instruction word
    always_ff @(posedge clk) begin
        if (fetch_start) begin
            fetch_addr <= pc;
        end
        if (fetch_done) begin
            inst <= rd_data;                // Held until the next fetch lands
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_start |-> !fetch_req);

endmodule

`default_nettype wire

/* verilog/load_store_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  mem_start,
    input  wire limn_pkg::word_t mem_addr,
    input  wire                  mem_we,
    input  wire limn_pkg::word_t mem_wdata,
    input  wire                  ls_done,
    input  wire limn_pkg::word_t rd_data,
    output logic                 ls_req,
    output limn_pkg::word_t      ls_addr,
    output logic                 ls_we,
    output limn_pkg::word_t      ls_wdata,
    output logic                 mem_done,
    output limn_pkg::word_t      load_data
);
    ////////////////////////////////
    // Transfer control
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ls_req   <= 1'b0;
            ls_we    <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= ls_done;
            if (mem_start) begin
                ls_req <= 1'b1;
                ls_we  <= mem_we;
            end else if (ls_done) begin
                ls_req <= 1'b0;
            end
        end
    end

    // Payload for the single transfer in flight
    always_ff @(posedge clk) begin
        if (mem_start) begin
            ls_addr  <= mem_addr;
            ls_wdata <= mem_wdata;
        end
        if (ls_done) begin
            load_data <= rd_data;     // Don't care after a store
        end
    end

    // Word transfers only
    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        mem_start |-> (mem_addr[1:0] == 2'b00));

endmodule

`default_nettype wire

/* verilog/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  fetch_req,
    input  wire limn_pkg::word_t fetch_addr,
    input  wire                  ls_req,
    input  wire limn_pkg::word_t ls_addr,
    input  wire                  ls_we,
    input  wire limn_pkg::word_t ls_wdata,
    input  wire limn_pkg::word_t data_in,
    input  wire                  rdy,
    output logic                 fetch_done,
    output logic                 ls_done,
    output limn_pkg::word_t      rd_data,
    output limn_pkg::word_t      addr,
    output limn_pkg::word_t      data_out,
    output logic                 we,
    output logic                 cs
);
    logic grant_fetch;
    logic grant_ls;

    // Grant is taken only while idle and dropped on rdy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_fetch <= 1'b0;
            grant_ls    <= 1'b0;
        end else if (!grant_fetch && !grant_ls) begin
            grant_ls    <= ls_req;               // Load/store wins a tie
            grant_fetch <= fetch_req && !ls_req;
        end else if (rdy) begin
            grant_fetch <= 1'b0;
            grant_ls    <= 1'b0;
        end
    end

    assign cs         = grant_fetch || grant_ls;
    assign we         = grant_ls && ls_we;
    assign addr       = grant_ls ? ls_addr : fetch_addr;
    assign data_out   = ls_wdata;
    assign rd_data    = data_in;     // Valid only in the rdy cycle
    assign fetch_done = grant_fetch && rdy;
    assign ls_done    = grant_ls && rdy;

    // The granted peer keeps its request open for the whole transfer
    a_grant_owner: assert property (@(posedge clk) disable iff (!rst_n)
        cs |-> (grant_ls ? ls_req : fetch_req));

    // Address must hold for the whole transfer
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (cs && !rdy) |=> $stable(addr));

endmodule

`default_nettype wire

/* verilog/limn_core.sv */
`timescale 1ns/1ps
`default_nettype none

module limn_core #(
    parameter limn_pkg::word_t reset_vector = 32'hFFFE_0000
) (
    input  wire                   clk,
    input  wire                   rst_n,
    output limn_pkg::word_t       addr,
    input  wire limn_pkg::word_t  data_in,
    output limn_pkg::word_t       data_out,
    output logic                  we,
    output logic                  cs,
    input  wire                   rdy,
    output logic                  halted
);
    import limn_pkg::*;

    // Execute to fetch
    logic     fetch_start;
    word_t    pc;
    logic     inst_valid;
    word_t    inst;

    // Execute to load/store
    logic     mem_start;
    word_t    mem_addr;
    logic     mem_we;
    word_t    mem_wdata;
    logic     mem_done;
    word_t    load_data;

    // Register file ports
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_data;
    word_t    rt_data;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;

    // Peer buses
    logic     fetch_req;
    word_t    fetch_addr;
    logic     fetch_done;
    logic     ls_req;
    word_t    ls_addr;
    logic     ls_we;
    word_t    ls_wdata;
    logic     ls_done;
    word_t    rd_data;

    execute_unit #(
        .reset_vector (reset_vector)
    ) u_execute_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .mem_done    (mem_done),
        .load_data   (load_data),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .fetch_start (fetch_start),
        .pc          (pc),
        .mem_start   (mem_start),
        .mem_addr    (mem_addr),
        .mem_we      (mem_we),
        .mem_wdata   (mem_wdata),
        .rs_idx      (rs_idx),
        .rt_idx      (rt_idx),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .halted      (halted)
    );

    register_file u_register_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_start (fetch_start),
        .pc          (pc),
        .fetch_done  (fetch_done),
        .rd_data     (rd_data),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .inst_valid  (inst_valid),
        .inst        (inst)
    );

    load_store_unit u_load_store_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_start (mem_start),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata),
        .ls_done   (ls_done),
        .rd_data   (rd_data),
        .ls_req    (ls_req),
        .ls_addr   (ls_addr),
        .ls_we     (ls_we),
        .ls_wdata  (ls_wdata),
        .mem_done  (mem_done),
        .load_data (load_data)
    );

    bus_arbiter u_bus_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .ls_req     (ls_req),
        .ls_addr    (ls_addr),
        .ls_we      (ls_we),
        .ls_wdata   (ls_wdata),
        .data_in    (data_in),
        .rdy        (rdy),
        .fetch_done (fetch_done),
        .ls_done    (ls_done),
        .rd_data    (rd_data),
        .addr       (addr),
        .data_out   (data_out),
        .we         (we),
        .cs         (cs)
    );

endmodule

`default_nettype wire

/* sim/tb_limn_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_limn_core;
    import limn_pkg::*;

    localparam word_t boot_addr  = 32'hFFFE_0000; // Core's default reset vector
    localparam word_t halt_word  = 32'h0000_003F; // Opcode 111111 is not decoded
    localparam int    max_cycles = 3000;

    logic  clk;
    logic  rst_n;
    word_t addr;
    word_t data_in;
    word_t data_out;
    logic  we;
    logic  cs;
    logic  rdy;
    logic  halted;

    word_t       mem [65536];    // Window FFFC0000 to FFFFFFFF
    word_t       prog [$];
    word_t       exp_addr [$];
    word_t       exp_data [$];
    word_t       halt_addr;
    logic        halt_fetched;
    logic [31:0] rng_state = 32'd76;

    limn_core u_limn_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out),
        .we       (we),
        .cs       (cs),
        .rdy      (rdy),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Background pattern, different for every word
    function automatic word_t fill_word(input word_t a);
        return {a[15:0], a[31:16]} ^ 32'h5AC3_3CA5;
    endfunction

    function automatic word_t enc(input opcode_t op, input reg_idx_t r1,
                                  input reg_idx_t r2, input logic [15:0] imm);
        return {imm, r2, r1, op};
    endfunction

    // Offset field shares bits 10:9 with opreg1
    function automatic word_t enc_branch(input opcode_t op, input reg_idx_t r,
                                         input logic [22:0] words);
        return {words, 9'd0} | {21'd0, r, 6'd0} | {26'd0, op};
    endfunction

    function automatic word_t enc_jump(input opcode_t op, input word_t target);
        return {target[30:2], 3'b000} | {26'd0, op};
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_now($sformatf("ERROR time %0t: %s is %08h, expected %08h",
                               $time, name, got, exp));
        end
    endtask

    task automatic new_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic pad_to(input int n);
        while (prog.size() < n) begin
            emit(32'h0000_0000);  // true nop
        end
    endtask

    task automatic expect_word(input word_t a, input word_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    task automatic load_program();
        word_t a;
        for (a = 32'hFFFC_0000; a != 32'd0; a += 32'd4) begin
            mem[a[17:2]] = fill_word(a);
        end
        foreach (prog[i]) begin
            a = boot_addr + word_t'(4 * i);
            mem[a[17:2]] = prog[i];
        end
    endtask

    //////////////////////////////
    // Memory model
    //////////////////////////////
    initial begin : memory_model
        logic  s_rst_n;
        logic  s_cs;
        logic  s_rdy;
        logic  s_we;
        word_t s_addr;
        word_t s_wdata;
        logic  busy;
        int    wait_left;
        busy      = 1'b0;
        wait_left = 0;
        rdy       = 1'b0;
        data_in   = '0;
        forever begin
            @(posedge clk);
            s_rst_n = rst_n;
            s_cs    = cs;
            s_rdy   = rdy;
            s_we    = we;
            s_addr  = addr;
            s_wdata = data_out;
            if (s_rst_n && s_cs && s_rdy) begin    // Transfer ends on this edge
                if (s_we) begin
                    mem[s_addr[17:2]] = s_wdata;
                end else if (s_addr == halt_addr) begin
                    halt_fetched = 1'b1;
                end
            end
            if (!s_rst_n || (s_cs && s_rdy)) begin
                busy = 1'b0;
            end
            #2;
            rdy     = 1'b0;
            data_in = '0;
            if (cs === 1'b1 && !busy) begin
                if (addr[31:18] != 14'h3FFF) begin
                    fail_now($sformatf("Bus access at %08h is outside the memory", addr));
                end
                busy      = 1'b1;
                wait_left = int'(next_rand() % 32'd4);  // 0 to 3 wait cycles
            end
            if (busy) begin
                if (wait_left == 0) begin
                    rdy = 1'b1;
                    if (!we) begin
                        data_in = mem[addr[17:2]];
                    end
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // Reset, run to halt, then compare memory with the model
    task automatic run_program(input string test_name);
        int cycles;
        halt_addr    = boot_addr + word_t'(4 * (prog.size() - 1));
        halt_fetched = 1'b0;
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_value({test_name, " halted after reset"}, {31'd0, halted}, 32'd0);
        cycles = 0;
        while (halted !== 1'b1) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > max_cycles) begin
                fail_now({test_name, ": timed out waiting for the core to halt"});
            end
        end
        if (!halt_fetched) begin
            fail_now({test_name, ": halted rose before the final instruction was fetched"});
        end
        repeat (4) begin  // Bus must stay quiet once halted
            @(posedge clk);
            #2;
            check_value({test_name, " cs"}, {31'd0, cs}, 32'd0);
            check_value({test_name, " halted"}, {31'd0, halted}, 32'd1);
        end
        foreach (exp_addr[i]) begin
            check_value($sformatf("%s mem[%08h]", test_name, exp_addr[i]),
                        mem[exp_addr[i][17:2]], exp_data[i]);
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic test_alu_ops();
        word_t       src;
        word_t       r;
        word_t       model [8];
        logic [15:0] k [6];
        logic [15:0] off;
        reg_idx_t    data_reg [8];
        new_program();
        src = next_rand();
        for (int i = 0; i < 6; i++) begin
            r    = next_rand();
            k[i] = r[15:0];
        end
        data_reg = '{5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd0};
        emit(enc(op_lui, 5'd1, 5'd0, boot_addr[31:16]));  // r1 = data base
        emit(enc(op_lui, 5'd3, 5'd0, src[31:16]));
        emit(enc(op_ori, 5'd3, 5'd3, src[15:0]));
        emit(enc(op_addi, 5'd4, 5'd3, k[0]));
        emit(enc(op_subi, 5'd5, 5'd3, k[1]));
        emit(enc(op_andi, 5'd6, 5'd3, k[2]));
        emit(enc(op_xori, 5'd7, 5'd3, k[3]));
        emit(enc(op_ori, 5'd8, 5'd3, k[4]));
        emit(enc(op_lui, 5'd9, 5'd3, k[5]));
        emit(enc(op_addi, 5'd0, 5'd3, k[0]));             // r0 must not change
        model[0] = src;
        model[1] = src + {16'd0, k[0]};
        model[2] = src - {16'd0, k[1]};
        model[3] = src & {16'd0, k[2]};
        model[4] = src ^ {16'd0, k[3]};
        model[5] = src | {16'd0, k[4]};
        model[6] = src | {k[5], 16'd0};
        model[7] = 32'd0;
        for (int i = 0; i < 8; i++) begin
            off = 16'h1000 + 16'(4 * i);
            emit(enc(op_store_reg, 5'd1, data_reg[i], off));
            expect_word(boot_addr + {16'd0, off}, model[i]);
        end
        emit(halt_word);
        load_program();
        run_program("alu");
    endtask

    // Branch 16 bytes ahead over a marker store and two nops
    task automatic branch_block(input opcode_t op, input reg_idx_t r,
                                input logic reg_zero, input logic [15:0] off);
        logic  taken;
        word_t a;
        taken = (op == op_beq) ? reg_zero : !reg_zero;
        a     = boot_addr + {16'd0, off};
        emit(enc_branch(op, r, 23'd4));
        emit(enc(op_store_reg, 5'd1, 5'd4, off));
        emit(32'h0000_0000);
        emit(32'h0000_0000);
        expect_word(a, taken ? fill_word(a) : 32'h0000_0077);
    endtask

    task automatic test_branches();
        word_t r;
        new_program();
        r = next_rand();
        emit(enc(op_lui, 5'd1, 5'd0, boot_addr[31:16]));
        emit(enc(op_ori, 5'd3, 5'd0, r[15:0] | 16'h0001)); // r3 nonzero, r2 stays zero
        emit(enc(op_ori, 5'd4, 5'd0, 16'h0077));             // Marker value
        branch_block(op_beq, 5'd2, 1'b1, 16'h2000);
        branch_block(op_beq, 5'd3, 1'b0, 16'h2004);
        branch_block(op_bne, 5'd3, 1'b0, 16'h2008);
        branch_block(op_bne, 5'd2, 1'b1, 16'h200C);
        emit(enc(op_store_reg, 5'd1, 5'd4, 16'h2010));
        expect_word(boot_addr + 32'h2010, 32'h0000_0077);
        emit(halt_word);
        load_program();
        run_program("branch");
    endtask

    task automatic test_jumps();
        word_t j_target;
        word_t jal_target;
        word_t jal_addr;
        new_program();
        j_target   = boot_addr + 32'h40;  // Targets need bits 4:2 clear
        jal_target = boot_addr + 32'h80;
        emit(enc(op_lui, 5'd1, 5'd0, boot_addr[31:16]));
        emit(enc(op_ori, 5'd4, 5'd0, 16'h0055));
        emit(enc_jump(op_j, j_target));
        emit(enc(op_store_reg, 5'd1, 5'd4, 16'h3000));      // Jumped over
        pad_to(int'((j_target - boot_addr) >> 2));
        emit(enc(op_store_reg, 5'd1, 5'd4, 16'h3004));
        jal_addr = boot_addr + word_t'(4 * prog.size());
        emit(enc_jump(op_jal, jal_target));
        emit(enc(op_store_reg, 5'd1, 5'd4, 16'h3008));      // Jumped over
        pad_to(int'((jal_target - boot_addr) >> 2));
        emit(enc(op_store_reg, 5'd1, reg_lr, 16'h300C));
        emit(halt_word);
        expect_word(boot_addr + 32'h3000, fill_word(boot_addr + 32'h3000));
        expect_word(boot_addr + 32'h3004, 32'h0000_0055);
        expect_word(boot_addr + 32'h3008, fill_word(boot_addr + 32'h3008));
        expect_word(boot_addr + 32'h300C, jal_addr + 32'd4);
        load_program();
        run_program("jump");
    endtask

    task automatic test_load_store();
        word_t       src0;
        word_t       src1;
        word_t       r;
        logic [4:0]  imm5;
        logic [15:0] off;
        new_program();
        emit(enc(op_lui, 5'd1, 5'd0, boot_addr[31:16]));
        emit(enc(op_load_long, 5'd5, 5'd1, 16'h4000));
        emit(enc(op_store_reg, 5'd1, 5'd5, 16'h4100));
        emit(enc(op_load_long, 5'd6, 5'd1, 16'h4004));
        emit(enc(op_store_reg, 5'd1, 5'd6, 16'h4104));
        for (int i = 0; i < 2; i++) begin
            r    = next_rand();
            imm5 = r[4:0];
            off  = {imm5, (i == 0) ? 11'h200 : 11'h204}; // imm5 also lands in imm16
            emit(enc(op_store_imm, 5'd1, 5'd0, off));
            expect_word(boot_addr + {16'd0, off}, {27'd0, imm5});
        end
        emit(halt_word);
        load_program();
        src0 = next_rand();
        src1 = next_rand();
        mem[(boot_addr + 32'h4000) >> 2 & 32'h0000_FFFF] = src0;
        mem[(boot_addr + 32'h4004) >> 2 & 32'h0000_FFFF] = src1;
        expect_word(boot_addr + 32'h4000, src0);
        expect_word(boot_addr + 32'h4004, src1);
        expect_word(boot_addr + 32'h4100, src0);
        expect_word(boot_addr + 32'h4104, src1);
        run_program("load_store");
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        rst_n        = 1'b0;
        halt_fetched = 1'b0;
        halt_addr    = '0;
        repeat (3) begin    // Fresh operands and rdy delays each round
            test_alu_ops();
            test_branches();
            test_jumps();
            test_load_store();
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* limn_core.f */
common/limn_pkg.sv
execute/register_file.sv
execute/execute_unit.sv
verilog/fetch_unit.sv
verilog/load_store_unit.sv
verilog/bus_arbiter.sv
verilog/limn_core.sv
sim/tb_limn_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the limn_core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

log_file="sim.log"

verilator --binary --timing --assert \
    -f limn_core.f \
    --top-module tb_limn_core \
    -o sim_limn_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_limn_core | tee "$log_file"
sim_status=${PIPESTATUS[0]}
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' "$log_file"; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail"
    exit 1
fi
